/* hdl/nnPkg.sv */
`default_nettype none

package nnPkg;

	// ------------------------------
	// layer sizes
	// ------------------------------
	localparam int NUM_INPUTS = 15; // activations per sample.
	localparam int NUM_NEURONS = 4;
	localparam int WORD_BITS = 24;
	localparam int ACT_BITS = 8;
	localparam int SAT_LIMIT = 4096; // any positive sum above this clips to full scale.
	localparam int BIAS_TAP = NUM_INPUTS; // the tap after the last weight holds the bias.
	localparam int TAP_BITS = $clog2(NUM_INPUTS + 1);
	localparam int NODE_BITS = $clog2(NUM_NEURONS);

	// ------------------------------
	// data types
	// ------------------------------
	typedef logic [WORD_BITS-1:0] wordT;
	typedef logic [ACT_BITS-1:0] actT;
	typedef wordT [NUM_INPUTS:0] weightRowT; // weights 0 to 14, then the bias.
	typedef weightRowT [NUM_NEURONS-1:0] weightMatrixT;
	typedef wordT [NUM_INPUTS-1:0] activationVecT;

	typedef struct packed
	{
		logic [NODE_BITS-1:0] neuron;
		logic [TAP_BITS-1:0] tap;
	} cfgAddrT;

	typedef enum logic [2:0]
	{
		COLLECT,
		IN_RELEASE,
		FIRE,
		WAIT_RESULT,
		EMIT,
		EMIT_RELEASE
	} seqStateT;

endpackage

`default_nettype wire

/* hdl/layerIf.sv */
`timescale 1ns/10ps
`default_nettype none

interface layerIf;

	logic fire; // one-cycle pulse that starts a sample in every neuron.
	nnPkg::activationVecT activations;
	logic [nnPkg::NUM_NEURONS-1:0] resultValid; // one bit per neuron.
	nnPkg::actT [nnPkg::NUM_NEURONS-1:0] results;

	modport seq
	(
		output fire,
		output activations,
		input resultValid,
		input results
	);

	modport node
	(
		input fire,
		input activations,
		output resultValid,
		output results
	);

endinterface

`default_nettype wire

/* hdl/weightBank.sv */
`timescale 1ns/10ps
`default_nettype none

module weightBank
(
	input logic clk,
	input logic reset,
	input logic cfgReq,
	input nnPkg::cfgAddrT cfgAddr,
	input nnPkg::wordT cfgData,
	output logic cfgAck,
	output nnPkg::weightMatrixT weights
);

	nnPkg::weightMatrixT bankRegs; // one row of weights and a bias per neuron.
	logic writeEn;

	// a request is served once, on the edge where the ack rises.
	assign writeEn = cfgReq && !cfgAck;

	// ------------------------------
	// configuration handshake
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			cfgAck <= 1'b0;
		end
		else if (writeEn)
		begin
			cfgAck <= 1'b1;
		end
		else if (!cfgReq && cfgAck)
		begin
			cfgAck <= 1'b0; // the host has released its request.
		end
	end

	// ------------------------------
	// register array
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			bankRegs <= '0; // an unloaded layer computes with zero weights.
		end
		else if (writeEn)
		begin
			bankRegs[cfgAddr.neuron][cfgAddr.tap] <= cfgData;
		end
	end

	assign weights = bankRegs;

endmodule

`default_nettype wire

/* hdl/neuronNode.sv */
`timescale 1ns/10ps
`default_nettype none

module neuronNode
#(
	parameter int NODE = 0
)
(
	input logic clk,
	input logic reset,
	input nnPkg::weightRowT weights,
	layerIf.node layer
);

	nnPkg::activationVecT actCap;
	nnPkg::wordT sumNext;
	nnPkg::wordT sumReg;
	nnPkg::actT actOut;
	logic valid1;
	logic valid2;
	logic valid3;

	// negative sums give zero, large sums clip, the rest keep bits 12 to 5.
	function automatic nnPkg::actT rectify(input nnPkg::wordT sum);
		nnPkg::actT result;
		if (sum[nnPkg::WORD_BITS-1])
			result = '0;
		else if (sum > nnPkg::SAT_LIMIT)
			result = '1;
		else
			result = sum[12:5];
		return result;
	endfunction

	// ------------------------------
	// valid tags
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			valid1 <= 1'b0;
			valid2 <= 1'b0;
			valid3 <= 1'b0;
		end
		else
		begin
			valid1 <= layer.fire;
			valid2 <= valid1;
			valid3 <= valid2;
		end
	end

	// ------------------------------
	// datapath
	// ------------------------------
	always_comb
	begin
		sumNext = weights[nnPkg::BIAS_TAP];
		for (int i = 0; i < nnPkg::NUM_INPUTS; i++)
			sumNext = sumNext + nnPkg::wordT'(actCap[i] * weights[i]); // wraps at 24 bits.
	end

	always_ff @(posedge clk)
	begin
		if (layer.fire)
			actCap <= layer.activations;
		if (valid1)
			sumReg <= sumNext;
		if (valid2)
			actOut <= rectify(sumReg);
	end

	assign layer.resultValid[NODE] = valid3;
	assign layer.results[NODE] = actOut;

endmodule

`default_nettype wire

/* hdl/layerSequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module layerSequencer
(
	input logic clk,
	input logic reset,
	input logic inReq,
	input nnPkg::wordT inData,
	output logic inAck,
	output logic outReq,
	output logic [1:0] outIndex,
	output nnPkg::actT outData,
	input logic outAck,
	layerIf.seq layer
);

	nnPkg::seqStateT state;
	logic [nnPkg::TAP_BITS-1:0] count; // index of the next activation.
	nnPkg::activationVecT actVec;
	nnPkg::actT [nnPkg::NUM_NEURONS-1:0] resultBuf;
	logic lastInput;
	logic lastOutput;

	assign lastInput = (count == nnPkg::TAP_BITS'(nnPkg::NUM_INPUTS - 1));
	assign lastOutput = (outIndex == 2'(nnPkg::NUM_NEURONS - 1));

	// ------------------------------
	// state machine
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= nnPkg::COLLECT;
			count <= '0;
			inAck <= 1'b0;
			outReq <= 1'b0;
			outIndex <= '0;
		end
		else
		begin
			case (state)
				nnPkg::COLLECT:
				begin
					if (inReq)
					begin
						inAck <= 1'b1;
						state <= nnPkg::IN_RELEASE;
					end
				end
				nnPkg::IN_RELEASE:
				begin
					if (!inReq)
					begin
						inAck <= 1'b0;
						if (lastInput)
						begin
							count <= '0;
							state <= nnPkg::FIRE;
						end
						else
						begin
							count <= count + 1'b1;
							state <= nnPkg::COLLECT;
						end
					end
				end
				nnPkg::FIRE:
				begin
					state <= nnPkg::WAIT_RESULT; // the neurons sample fire on this edge.
				end
				nnPkg::WAIT_RESULT:
				begin
					if (&layer.resultValid)
					begin
						outIndex <= '0;
						outReq <= 1'b1;
						state <= nnPkg::EMIT;
					end
				end
				nnPkg::EMIT:
				begin
					if (outAck)
					begin
						outReq <= 1'b0;
						state <= nnPkg::EMIT_RELEASE;
					end
				end
				nnPkg::EMIT_RELEASE:
				begin
					if (!outAck)
					begin
						if (lastOutput)
						begin
							state <= nnPkg::COLLECT; // the sample is done.
						end
						else
						begin
							outIndex <= outIndex + 2'd1;
							outReq <= 1'b1;
							state <= nnPkg::EMIT;
						end
					end
				end
				default:
				begin
					state <= nnPkg::COLLECT;
				end
			endcase
		end
	end

	// ------------------------------
	// payload registers
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (state == nnPkg::COLLECT && inReq)
			actVec[count] <= inData;
		if (state == nnPkg::WAIT_RESULT && &layer.resultValid)
			resultBuf <= layer.results;
	end

	assign layer.fire = (state == nnPkg::FIRE);
	assign layer.activations = actVec;
	assign outData = resultBuf[outIndex]; // both operands are held while outReq is high.

endmodule

`default_nettype wire

/* hdl/denseLayer.sv */
`timescale 1ns/10ps
`default_nettype none

module denseLayer
(
	input logic clk,
	input logic reset,
	input logic cfgReq,
	input nnPkg::cfgAddrT cfgAddr,
	input nnPkg::wordT cfgData,
	output logic cfgAck,
	input logic inReq,
	input nnPkg::wordT inData,
	output logic inAck,
	output logic outReq,
	output logic [1:0] outIndex,
	output nnPkg::actT outData,
	input logic outAck
);

	nnPkg::weightMatrixT weightRows;

	layerIf layerBus();

	weightBank bank
	(
		.clk(clk),
		.reset(reset),
		.cfgReq(cfgReq),
		.cfgAddr(cfgAddr),
		.cfgData(cfgData),
		.cfgAck(cfgAck),
		.weights(weightRows)
	);

	layerSequencer sequencer
	(
		.clk(clk),
		.reset(reset),
		.inReq(inReq),
		.inData(inData),
		.inAck(inAck),
		.outReq(outReq),
		.outIndex(outIndex),
		.outData(outData),
		.outAck(outAck),
		.layer(layerBus.seq)
	);

	// ------------------------------
	// neurons
	// ------------------------------
	for (genvar n = 0; n < nnPkg::NUM_NEURONS; n++)
	begin : gNeuron
		neuronNode #(.NODE(n)) node
		(
			.clk(clk),
			.reset(reset),
			.weights(weightRows[n]),
			.layer(layerBus.node)
		);
	end

endmodule

`default_nettype wire

/* sim/denseLayer_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

module denseLayer_asserts
(
	input logic clk,
	input logic reset,
	input logic cfgReq,
	input logic cfgAck,
	input logic inReq,
	input logic inAck,
	input logic outReq,
	input logic outAck,
	input logic [1:0] outIndex,
	input nnPkg::actT outData
);

	// ------------------------------
	// handshake rules
	// ------------------------------
	cfgAckHasReq: assert property (@(posedge clk) disable iff (reset)
		$rose(cfgAck) |-> $past(cfgReq)) else $error("cfgAck rose without cfgReq");

	// activations are only taken while no result is on offer.
	inAckHasReq: assert property (@(posedge clk) disable iff (reset)
		$rose(inAck) |-> $past(inReq) && !outReq) else $error("inAck rose out of turn");

	outAckHasReq: assert property (@(posedge clk) disable iff (reset)
		$rose(outAck) |-> outReq) else $error("outAck rose without outReq");

	outReqHeld: assert property (@(posedge clk) disable iff (reset)
		outReq && !outAck |=> outReq) else $error("outReq dropped before outAck");

	outPayloadStable: assert property (@(posedge clk) disable iff (reset)
		outReq && $past(outReq) |-> $stable(outData) && $stable(outIndex))
		else $error("outData or outIndex changed while outReq was high");

	lowAfterReset: assert property (@(posedge clk)
		$fell(reset) |-> !cfgAck && !inAck && !outReq)
		else $error("a handshake output was high after reset");

endmodule

bind denseLayer denseLayer_asserts asserts
(
	.clk(clk),
	.reset(reset),
	.cfgReq(cfgReq),
	.cfgAck(cfgAck),
	.inReq(inReq),
	.inAck(inAck),
	.outReq(outReq),
	.outAck(outAck),
	.outIndex(outIndex),
	.outData(outData)
);

`default_nettype wire

/* sim/denseLayerTb.sv */
`timescale 1ns/10ps
`default_nettype none

module denseLayerTb;

	localparam string TRACE_FILE = "sim/layerTrace.txt";
	localparam int RESET_CYCLES = 8;
	localparam int CYCLES_PER_STEP = 40;

	logic clk;
	logic reset;
	logic cfgReq;
	nnPkg::cfgAddrT cfgAddr;
	nnPkg::wordT cfgData;
	logic cfgAck;
	logic inReq;
	nnPkg::wordT inData;
	logic inAck;
	logic outReq;
	logic [1:0] outIndex;
	nnPkg::actT outData;
	logic outAck;

	int errors = 0;
	int checks = 0;
	int testErrors = 0;
	int testsDone = 0;
	int cycleCount = 0;
	int cycleLimit = 0;
	int resultsOwed = 0; // expected results not yet read by the host.
	logic [1:0] expIndexQ[$];
	nnPkg::actT expValueQ[$];
	int ackDelayQ[$];
	string testName = "reset_levels";
	string activeChannel = "reset";

	denseLayer DUT
	(
		.clk(clk),
		.reset(reset),
		.cfgReq(cfgReq),
		.cfgAddr(cfgAddr),
		.cfgData(cfgData),
		.cfgAck(cfgAck),
		.inReq(inReq),
		.inData(inData),
		.inAck(inAck),
		.outReq(outReq),
		.outIndex(outIndex),
		.outData(outData),
		.outAck(outAck)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ------------------------------
	// host channels
	// ------------------------------
	task automatic stepClock();
		@(posedge clk);
		#1; // inputs change just after the edge.
	endtask

	task automatic cfgWrite(input nnPkg::cfgAddrT addr, input nnPkg::wordT data);
		activeChannel = "configuration";
		cfgAddr = addr;
		cfgData = data;
		cfgReq = 1'b1;
		do stepClock(); while (!cfgAck);
		cfgReq = 1'b0;
		do stepClock(); while (cfgAck);
	endtask

	task automatic inWrite(input nnPkg::wordT data, input int delay);
		activeChannel = "input";
		repeat (delay) stepClock(); // host idles before it offers the word.
		inData = data;
		inReq = 1'b1;
		do stepClock(); while (!inAck);
		if (resultsOwed != 0)
		begin
			$display("an activation was accepted while %0d results were still unread",
				resultsOwed);
			errors++;
			testErrors++;
		end
		inReq = 1'b0;
		do stepClock(); while (inAck);
	endtask

	task automatic outRead(input logic [1:0] expIndex, input nnPkg::actT expValue, input int delay);
		activeChannel = "output";
		while (!outReq)
			stepClock();
		checkIndex("outIndex", expIndex, outIndex);
		checkAct("outData", expValue, outData);
		repeat (delay) stepClock();
		outAck = 1'b1;
		do stepClock(); while (outReq);
		outAck = 1'b0;
	endtask

	task automatic waitResultsRead();
		wait (resultsOwed == 0);
	endtask

	// ------------------------------
	// compare tasks
	// ------------------------------
	task automatic checkAct(input string name, input nnPkg::actT expected, input nnPkg::actT actual);
		checks++;
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
			errors++;
			testErrors++;
		end
	endtask

	task automatic checkIndex(input string name, input logic [1:0] expected, input logic [1:0] actual);
		checks++;
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
			errors++;
			testErrors++;
		end
	endtask

	task automatic checkLow(input string name, input logic actual);
		checks++;
		if (actual !== 1'b0)
		begin
			$display("CHECK FAILED %s expected 0 actual %h", name, actual);
			errors++;
			testErrors++;
		end
	endtask

	task automatic finishTest();
		$display("test %s finished with %0d errors", testName, testErrors);
		testsDone++;
		testErrors = 0;
	endtask

	// an activation line stands for one handshake per input.
	function automatic int countSteps();
		int fd;
		int steps;
		string line;
		steps = 0;
		fd = $fopen(TRACE_FILE, "r");
		if (fd != 0)
		begin
			while ($fgets(line, fd) != 0)
			begin
				if (line.len() > 0 && line[0] == "A")
					steps += nnPkg::NUM_INPUTS;
				else
					steps++;
			end
			$fclose(fd);
		end
		return steps;
	endfunction

	task automatic runTrace();
		int fd;
		int n;
		int addr;
		int data;
		int delay;
		int idx;
		int vals[nnPkg::NUM_INPUTS];
		string line;
		string name;
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0)
		begin
			$display("could not open the trace file %s", TRACE_FILE);
			errors++;
			return;
		end
		while ($fgets(line, fd) != 0)
		begin
			if (line.len() < 2 || line[0] == "#")
				continue;
			case (line[0])
				"T":
				begin
					n = $sscanf(line, "T %s", name);
					waitResultsRead();
					finishTest();
					testName = name;
				end
				"W":
				begin
					n = $sscanf(line, "W %h %h", addr, data);
					waitResultsRead(); // no weight changes while a sample is in flight.
					cfgWrite(6'(addr), 24'(data));
				end
				"A":
				begin
					n = $sscanf(line, "A %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", delay,
						vals[0], vals[1], vals[2], vals[3], vals[4], vals[5], vals[6], vals[7],
						vals[8], vals[9], vals[10], vals[11], vals[12], vals[13], vals[14]);
					if (n != nnPkg::NUM_INPUTS + 1)
					begin
						$display("activation line in test %s has too few fields", testName);
						errors++;
						testErrors++;
					end
					for (int i = 0; i < nnPkg::NUM_INPUTS; i++)
						inWrite(24'(vals[i]), delay);
				end
				"E":
				begin
					n = $sscanf(line, "E %d %h %d", idx, data, delay);
					expIndexQ.push_back(2'(idx));
					expValueQ.push_back(8'(data));
					ackDelayQ.push_back(delay);
					resultsOwed++;
				end
				default:
				begin
					$display("unknown line in the trace file: %s", line);
					errors++;
					testErrors++;
				end
			endcase
		end
		waitResultsRead();
		$fclose(fd);
	endtask

	// ------------------------------
	// host output side
	// ------------------------------
	initial
	begin
		forever
		begin
			wait (resultsOwed > 0); // runs beside the reader, so a new sample can wait at the input.
			outRead(expIndexQ[0], expValueQ[0], ackDelayQ[0]);
			void'(expIndexQ.pop_front());
			void'(expValueQ.pop_front());
			void'(ackDelayQ.pop_front());
			resultsOwed--;
		end
	end

	// ------------------------------
	// watchdog and main sequence
	// ------------------------------
	initial
	begin
		wait (cycleLimit > 0);
		while (cycleCount < cycleLimit)
		begin
			@(posedge clk);
			cycleCount++;
		end
		$display("timeout after %0d cycles, the %s handshake never completed", cycleCount,
			activeChannel);
		$display("Test failed");
		$finish;
	end

	initial
	begin
		reset = 1'b1;
		cfgReq = 1'b0;
		cfgAddr = '0;
		cfgData = '0;
		inReq = 1'b0;
		inData = '0;
		outAck = 1'b0;
		cycleLimit = RESET_CYCLES + CYCLES_PER_STEP * countSteps();
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;
		stepClock();
		checkLow("cfgAck", cfgAck);
		checkLow("inAck", inAck);
		checkLow("outReq", outReq);
		runTrace();
		finishTest();
		$display("%0d tests, %0d checks, %0d errors", testsDone, checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* sim/layerTrace.txt */
# T name | W addr data (hex) | A hostDelay act0..act14 (hex) | E index value (hex) ackDelay
# addr is neuron*16+tap, tap f is the bias; delays are clock cycles spent by the host.
T zero_weights
A 0 1 2 3 4 5 6 7 8 9 a b c d e f
E 0 00 0
E 1 00 0
E 2 00 0
E 3 00 0
T patterns
W 00 000010
W 01 000020
W 0e 000008
W 0f 000064
W 17 000200
W 20 fffff0
W 3e 000200
A 1 1 2 3 4 5 6 7 8 9 a b c d e f
E 0 09 0
E 1 80 1
E 2 00 0
E 3 ff 2
T bias_only
W 0f 000020
W 1f 000040
W 2f 000fff
W 3f 001f40
A 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
E 0 01 0
E 1 02 0
E 2 7f 0
E 3 ff 0
T back_to_back
A 0 2 3 0 0 0 0 0 4 0 0 0 0 0 0 5
E 0 06 9
E 1 42 12
E 2 7e 7
E 3 ff 15
A 2 200 0 0 0 0 0 0 0 0 0 0 0 0 0 0
E 0 ff 11
E 1 02 6
E 2 00 14
E 3 ff 10
T weight_rewrite
W 17 000100
A 0 2 3 0 0 0 0 0 4 0 0 0 0 0 0 5
E 0 06 0
E 1 22 3
E 2 7e 0
E 3 ff 0

/* sources.f */
hdl/nnPkg.sv
hdl/layerIf.sv
hdl/weightBank.sv
hdl/neuronNode.sv
hdl/layerSequencer.sv
hdl/denseLayer.sv
sim/denseLayer_asserts.sv
sim/denseLayerTb.sv

/* runSim.sh */
#!/bin/sh
# Build and run the dense layer testbench with Verilator from the project root.
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -f sources.f --top-module denseLayerTb \
	-Mdir "$BUILD" -o simv
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD/simv" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" "$LOG"; then
	exit 1
fi
if ! grep -q "Test passed" "$LOG"; then
	echo "simulation ended without a verdict"
	exit 1
fi
exit 0
